//--- Makefile
# Verilator build and run for the fetch core testbench

VERILATOR ?= verilator
TOP       ?= fetch_core_tb
FILELIST  ?= fetch_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/fetch_core_sva.sv
// Bound assertions for the fetch core top level
// In-flight limit, result hold under back-pressure, reset state

`timescale 1ns/100ps
`include "fetch_core_macros.svh"

module fetch_core_sva (
  input logic                     clk,
  input logic                     rst,
  input logic                     imem_req_val,
  input logic                     imem_req_rdy,
  input logic                     imem_resp_val,
  input logic                     imem_resp_rdy,
  input logic                     res_val,
  input logic                     res_rdy,
  input fetch_core_pkg::addr_t    res_pc,
  input fetch_core_pkg::reg_idx_t res_rd,
  input logic                     res_we,
  input fetch_core_pkg::word_t    res_data
);
  import fetch_core_pkg::*;

  logic                          req_xfer;
  logic                          resp_xfer;
  logic [`FC_IN_FLIGHT_BITS-1:0] in_flight;

  assign req_xfer  = imem_req_val && imem_req_rdy;
  assign resp_xfer = imem_resp_val && imem_resp_rdy;

  // Outstanding reads seen at the memory ports
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else if (req_xfer && !resp_xfer) begin
      in_flight <= in_flight + 1'b1;
    end else if (resp_xfer && !req_xfer) begin
      in_flight <= in_flight - 1'b1;
    end
  end

  // --------------------
  // Properties
  // --------------------

  // No new request once the limit is reached
  req_limit: assert property (@(posedge clk) disable iff (rst)
    (in_flight == `FC_IN_FLIGHT_BITS'(`FC_MAX_IN_FLIGHT)) |-> !imem_req_val)
    else $error("request valid with the in-flight limit reached");

  // Stalled result keeps val and payload
  res_hold: assert property (@(posedge clk) disable iff (rst)
    (res_val && !res_rdy) |=> (res_val && $stable(res_pc) && $stable(res_rd) &&
                               $stable(res_we) && $stable(res_data)))
    else $error("result changed while res_rdy was low");

  // Empty pipeline right after reset
  reset_clear: assert property (@(posedge clk) rst |=> !res_val)
    else $error("res_val high in the cycle after reset");

endmodule

//--- bench/fetch_core_tb.sv
// Testbench for the fetch core
// Clock, reset, instruction memory model, reference model
// Compare tasks, three test phases and the closing summary

`timescale 1ns/100ps
`include "fetch_core_macros.svh"

module fetch_core_tb;
  import fetch_core_pkg::*;

  logic     clk;
  logic     rst;
  logic     imem_req_val;
  logic     imem_req_rdy;
  addr_t    imem_req_addr;
  logic     imem_resp_val;
  logic     imem_resp_rdy;
  addr_t    imem_resp_addr;
  inst_t    imem_resp_data;
  logic     res_val;
  logic     res_rdy;
  addr_t    res_pc;
  reg_idx_t res_rd;
  logic     res_we;
  word_t    res_data;

  // Memory model, one random word per fetched address
  inst_t    mem_map [addr_t];
  addr_t    req_q [$];
  int       due_q [$];
  int       cycle;
  int       outstanding;
  addr_t    exp_req_addr;
  // Stimulus knobs, set per test
  int       max_delay;
  logic     rdy_random;
  logic     req_random;
  // Reference register file in program order
  word_t    model_regs [`FC_NUM_REGS];
  addr_t    exp_res_pc;
  int       retired;
  // Counters
  int       check_count;
  int       error_count;
  int       pc_errors;
  int       data_errors;
  int       nowrite_errors;
  int       nowrite_seen;
  int       flight_errors;
  int       flight_checks;
  logic     timed_out;

  fetch_core_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .imem_req_val   (imem_req_val),
    .imem_req_rdy   (imem_req_rdy),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_rdy  (imem_resp_rdy),
    .imem_resp_addr (imem_resp_addr),
    .imem_resp_data (imem_resp_data),
    .res_val        (res_val),
    .res_rdy        (res_rdy),
    .res_pc         (res_pc),
    .res_rd         (res_rd),
    .res_we         (res_we),
    .res_data       (res_data)
  );

  bind fetch_core_top fetch_core_sva sva0 (
    .clk           (clk),
    .rst           (rst),
    .imem_req_val  (imem_req_val),
    .imem_req_rdy  (imem_req_rdy),
    .imem_resp_val (imem_resp_val),
    .imem_resp_rdy (imem_resp_rdy),
    .res_val       (res_val),
    .res_rdy       (res_rdy),
    .res_pc        (res_pc),
    .res_rd        (res_rd),
    .res_we        (res_we),
    .res_data      (res_data)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // --------------------
  // Stimulus helpers
  // --------------------

  // Mostly low registers, so hazards come often
  function automatic reg_idx_t rand_reg();
    if ($urandom_range(0, 3) == 0) begin
      return reg_idx_t'($urandom_range(0, 15));
    end
    return reg_idx_t'($urandom_range(0, 7));
  endfunction

  // Biased toward ALU ops, every opcode still shows up
  function automatic inst_t random_inst();
    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    imm_t     imm;
    if ($urandom_range(0, 3) == 0) begin
      op = opcode_t'($urandom_range(0, 15));
    end else begin
      op = opcode_t'($urandom_range(1, 7));
    end
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    imm = imm_t'($urandom);
    return {op, rd, rs1, rs2, imm};
  endfunction

  // ALU rules of the instruction set
  function automatic word_t expected_result(opcode_t op, word_t a, word_t b, imm_t imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + {{16{imm[15]}}, imm};
      OP_LUI:  return {imm, 16'h0000};
      default: return '0;
    endcase
  endfunction

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_addr(input addr_t got, input addr_t exp, input string what,
                            inout int cat_errors);
    check_count++;
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
      cat_errors++;
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what,
                            inout int cat_errors);
    check_count++;
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
      cat_errors++;
    end
  endtask

  task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what,
                           inout int cat_errors);
    check_count++;
    if (got !== exp) begin
      $display("error at %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
      error_count++;
      cat_errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what,
                           inout int cat_errors);
    check_count++;
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
      cat_errors++;
    end
  endtask

  // One retired instruction against the reference model
  task automatic check_retire();
    inst_t    inst;
    opcode_t  op;
    reg_idx_t rd;
    word_t    value;
    logic     we;
    check_addr(res_pc, exp_res_pc, "retired pc", pc_errors);
    check_bit(logic'(mem_map.exists(exp_res_pc)), 1'b1, "retired pc was fetched", pc_errors);
    inst  = mem_map.exists(exp_res_pc) ? mem_map[exp_res_pc] : '0;
    op    = inst[31:28];
    rd    = inst[27:24];
    value = expected_result(op, model_regs[inst[23:20]], model_regs[inst[19:16]],
                            inst[15:0]);
    // r0 and the NOP codes write nothing
    we    = (op >= OP_ADD) && (op <= OP_LUI) && (rd != '0);
    check_reg(res_rd, rd, "res_rd", data_errors);
    if (we) begin
      check_bit(res_we, 1'b1, "res_we", data_errors);
      check_word(res_data, value, "res_data", data_errors);
      model_regs[rd] = value;
    end else begin
      nowrite_seen++;
      check_bit(res_we, 1'b0, "res_we on a no-write instruction", nowrite_errors);
    end
    exp_res_pc = exp_res_pc + 32'd4;
    retired++;
  endtask

  // --------------------
  // Monitor on the rising edge
  // --------------------

  always @(posedge clk) begin
    if (!rst) begin
      cycle++;
      // Request offered exactly while below the read limit
      check_bit(imem_req_val, logic'(outstanding < `FC_MAX_IN_FLIGHT),
                "imem_req_val against outstanding reads", flight_errors);
      if (imem_req_val && imem_req_rdy) begin
        check_addr(imem_req_addr, exp_req_addr, "request address", pc_errors);
        exp_req_addr = exp_req_addr + 32'd4;
        if (!mem_map.exists(imem_req_addr)) begin
          mem_map[imem_req_addr] = random_inst();
        end
        req_q.push_back(imem_req_addr);
        due_q.push_back(cycle + int'($urandom_range(0, max_delay)));
        outstanding++;
      end
      // Response is always the queue head
      if (imem_resp_val && imem_resp_rdy) begin
        void'(req_q.pop_front());
        void'(due_q.pop_front());
        outstanding--;
      end
      flight_checks++;
      check_bit(logic'(outstanding <= `FC_MAX_IN_FLIGHT), 1'b1,
                "in-flight reads within limit", flight_errors);
      if (res_val && res_rdy) begin
        check_retire();
      end
    end
  end

  // --------------------
  // Driver on the falling edge
  // --------------------

  always @(negedge clk) begin
    imem_req_rdy <= req_random ? ($urandom_range(0, 3) != 0) : 1'b1;
    res_rdy      <= rdy_random ? logic'($urandom_range(0, 1)) : 1'b1;
    // Head stays presented until it is taken
    if (req_q.size() > 0 && cycle >= due_q[0]) begin
      imem_resp_val  <= 1'b1;
      imem_resp_addr <= req_q[0];
      imem_resp_data <= mem_map[req_q[0]];
    end else begin
      imem_resp_val  <= 1'b0;
      imem_resp_addr <= '0;
      imem_resp_data <= '0;
    end
  end

  // Runs until count more instructions retire, or times out
  task automatic run_test(input string name, input int count, input int delay,
                          input logic rdy_rand, input logic req_rand);
    int target;
    int waited;
    int start_errors;
    max_delay    <= delay;
    rdy_random   <= rdy_rand;
    req_random   <= req_rand;
    start_errors = error_count;
    target       = retired + count;
    waited       = 0;
    while (retired < target && waited < count * 40 + 200) begin
      @(negedge clk);
      waited++;
    end
    if (retired < target) begin
      $display("timeout in %s: %0d of %0d instructions retired", name,
               count - (target - retired), count);
      timed_out = 1'b1;
      error_count++;
    end else begin
      $display("%s: %0d retired, %0d errors", name, count, error_count - start_errors);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    void'($urandom(32'h5012130c));
    clk            = 1'b0;
    rst            = 1'b1;
    imem_req_rdy   = 1'b0;
    imem_resp_val  = 1'b0;
    imem_resp_addr = '0;
    imem_resp_data = '0;
    res_rdy        = 1'b0;
    max_delay      = 0;
    rdy_random     = 1'b0;
    req_random     = 1'b0;
    cycle          = 0;
    outstanding    = 0;
    retired        = 0;
    check_count    = 0;
    error_count    = 0;
    pc_errors      = 0;
    data_errors    = 0;
    nowrite_errors = 0;
    nowrite_seen   = 0;
    flight_errors  = 0;
    flight_checks  = 0;
    timed_out      = 1'b0;
    exp_req_addr   = `FC_RESET_ADDR;
    exp_res_pc     = `FC_RESET_ADDR;
    for (int i = 0; i < `FC_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
    // Free flow first, then memory delays, then back-pressure
    run_test("pc_order", 40, 0, 1'b0, 1'b0);
    if (!timed_out) begin
      run_test("alu_results", 300, 3, 1'b0, 1'b0);
    end
    if (!timed_out) begin
      run_test("backpressure", 200, 3, 1'b1, 1'b1);
    end
    $display("r0_nop: %0d no-write instructions, %0d errors", nowrite_seen, nowrite_errors);
    $display("in_flight: %0d cycles, %0d errors", flight_checks, flight_errors);
    $display("summary: %0d retired, %0d checks, %0d errors (pc %0d, data %0d)",
             retired, check_count, error_count, pc_errors, data_errors);
    if (error_count == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- fetch_core.f
+incdir+rtl
rtl/fetch_core_pkg.sv
rtl/fetch_core_ifs.sv
rtl/fetch_unit.sv
rtl/inst_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/fetch_core_top.sv
bench/fetch_core_sva.sv
bench/fetch_core_tb.sv

//--- rtl/alu_execute.sv
// Execute stage
// Single-cycle ALU and its output register

`timescale 1ns/100ps

module alu_execute (
  input logic                clk,
  input logic                rst,
  decode_execute_if.consumer dx,
  execute_result_if.producer xr
);
  import fetch_core_pkg::*;

  imm_t     imm;
  word_t    result;
  logic     we;
  logic     in_xfer;
  logic     out_val;
  addr_t    out_pc;
  reg_idx_t out_rd;
  word_t    out_data;
  logic     out_we;

  // --------------------
  // ALU
  // --------------------

  // Immediate sits in the low half of b
  assign imm = dx.b[15:0];

  always_comb begin
    case (dx.op)
      OP_ADD:  result = dx.a + dx.b;
      OP_SUB:  result = dx.a - dx.b;
      OP_AND:  result = dx.a & dx.b;
      OP_OR:   result = dx.a | dx.b;
      OP_XOR:  result = dx.a ^ dx.b;
      OP_ADDI: result = dx.a + {{16{imm[15]}}, imm};
      OP_LUI:  result = {imm, 16'h0000};
      // NOP and the unused codes
      default: result = '0;
    endcase
  end

  // Real ops only, and never r0
  assign we = (dx.op >= OP_ADD) && (dx.op <= OP_LUI) && (dx.rd != '0);

  // --------------------
  // Output register
  // --------------------

  assign dx.rdy  = !out_val || xr.rdy;
  assign in_xfer = dx.val && dx.rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
    end else if (in_xfer) begin
      out_val <= 1'b1;
    end else if (xr.rdy) begin
      out_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      out_pc   <= dx.pc;
      out_rd   <= dx.rd;
      out_data <= result;
      out_we   <= we;
    end
  end

  assign xr.val  = out_val;
  assign xr.pc   = out_pc;
  assign xr.rd   = out_rd;
  assign xr.data = out_data;
  assign xr.we   = out_we;

endmodule

//--- rtl/fetch_core_ifs.sv
// Internal val/rdy interfaces between the core stages
// Fetch to decode, decode to execute, execute to result, register file

`timescale 1ns/100ps

// Fetched instruction with its address
interface fetch_decode_if;
  import fetch_core_pkg::*;
  logic  val;
  logic  rdy;
  addr_t pc;
  inst_t inst;
  modport fetch  (output val, pc, inst, input rdy);
  modport decode (input val, pc, inst, output rdy);
endinterface

// Decoded instruction with operands
interface decode_execute_if;
  import fetch_core_pkg::*;
  logic     val;
  logic     rdy;
  addr_t    pc;
  opcode_t  op;
  reg_idx_t rd;
  word_t    a;
  // rs2 value or raw immediate in the low half
  word_t    b;
  modport producer (output val, pc, op, rd, a, b, input rdy);
  modport consumer (input val, pc, op, rd, a, b, output rdy);
endinterface

// Executed result on its way to retire
interface execute_result_if;
  import fetch_core_pkg::*;
  logic     val;
  logic     rdy;
  addr_t    pc;
  reg_idx_t rd;
  word_t    data;
  logic     we;
  modport producer (output val, pc, rd, data, we, input rdy);
  modport consumer (input val, pc, rd, data, we, output rdy);
endinterface

// Operand reads plus retire notice for the scoreboard
interface regfile_if;
  import fetch_core_pkg::*;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rdata1;
  word_t    rdata2;
  logic     retire_val;
  reg_idx_t retire_rd;
  modport read    (output rs1, rs2, input rdata1, rdata2, retire_val, retire_rd);
  modport regfile (input rs1, rs2, output rdata1, rdata2, retire_val, retire_rd);
endinterface

//--- rtl/fetch_core_macros.svh
// Size and address constants for the fetch core
// Reset fetch address, in-flight read limit, register count

`ifndef FETCH_CORE_MACROS_SVH
`define FETCH_CORE_MACROS_SVH

// First instruction address after reset
`define FC_RESET_ADDR 32'h0000_0100

// Most instruction reads allowed outstanding at once
`define FC_MAX_IN_FLIGHT 4

// Counter width, must hold FC_MAX_IN_FLIGHT itself
`define FC_IN_FLIGHT_BITS 3

// Architectural registers, r0 included
`define FC_NUM_REGS 16

`endif

//--- rtl/fetch_core_pkg.sv
// Shared types for the fetch core
// Vector typedefs for addresses, words and instruction fields
// Opcode constants

package fetch_core_pkg;

  // --------------------
  // Vector types
  // --------------------

  // Byte address of an instruction word
  typedef logic [31:0] addr_t;
  // Raw 32-bit instruction
  typedef logic [31:0] inst_t;
  // Register and ALU data
  typedef logic [31:0] word_t;
  // Register index, 16 registers
  typedef logic [3:0]  reg_idx_t;
  // Top four bits of the instruction
  typedef logic [3:0]  opcode_t;
  // Low half of the instruction
  typedef logic [15:0] imm_t;

  // --------------------
  // Opcode values
  // --------------------

  // Codes 8 to 15 decode as NOP
  localparam opcode_t OP_NOP  = 4'd0;
  localparam opcode_t OP_ADD  = 4'd1;
  localparam opcode_t OP_SUB  = 4'd2;
  localparam opcode_t OP_AND  = 4'd3;
  localparam opcode_t OP_OR   = 4'd4;
  localparam opcode_t OP_XOR  = 4'd5;
  // Sign-extended immediate added to rs1
  localparam opcode_t OP_ADDI = 4'd6;
  // Immediate placed in the upper half
  localparam opcode_t OP_LUI  = 4'd7;

endpackage

//--- rtl/fetch_core_top.sv
// Fetch core top level
// Fetch, decode, execute and result stages joined by interfaces

`timescale 1ns/100ps

module fetch_core_top (
  input  logic                     clk,
  input  logic                     rst,

  // Instruction memory request
  output logic                     imem_req_val,
  input  logic                     imem_req_rdy,
  output fetch_core_pkg::addr_t    imem_req_addr,

  // Instruction memory response
  input  logic                     imem_resp_val,
  output logic                     imem_resp_rdy,
  input  fetch_core_pkg::addr_t    imem_resp_addr,
  input  fetch_core_pkg::inst_t    imem_resp_data,

  // Retired instruction
  output logic                     res_val,
  input  logic                     res_rdy,
  output fetch_core_pkg::addr_t    res_pc,
  output fetch_core_pkg::reg_idx_t res_rd,
  output logic                     res_we,
  output fetch_core_pkg::word_t    res_data
);

  // Stage links
  fetch_decode_if   fd_if ();
  decode_execute_if dx_if ();
  execute_result_if xr_if ();
  regfile_if        rf_if ();

  // --------------------
  // Stages
  // --------------------

  fetch_unit fetch0 (
    .clk            (clk),
    .rst            (rst),
    .imem_req_val   (imem_req_val),
    .imem_req_rdy   (imem_req_rdy),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_rdy  (imem_resp_rdy),
    .imem_resp_addr (imem_resp_addr),
    .imem_resp_data (imem_resp_data),
    .fd             (fd_if.fetch)
  );

  inst_decode decode0 (
    .clk (clk),
    .rst (rst),
    .fd  (fd_if.decode),
    .rf  (rf_if.read),
    .dx  (dx_if.producer)
  );

  alu_execute execute0 (
    .clk (clk),
    .rst (rst),
    .dx  (dx_if.consumer),
    .xr  (xr_if.producer)
  );

  // Also owns the register file
  result_writeback result0 (
    .clk      (clk),
    .rst      (rst),
    .xr       (xr_if.consumer),
    .rf       (rf_if.regfile),
    .res_val  (res_val),
    .res_rdy  (res_rdy),
    .res_pc   (res_pc),
    .res_rd   (res_rd),
    .res_we   (res_we),
    .res_data (res_data)
  );

endmodule

//--- rtl/fetch_unit.sv
// Instruction fetch unit
// Sequential address counter, in-flight read limit, response pass-through

`timescale 1ns/100ps
`include "fetch_core_macros.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,

  // Memory request side
  output logic                  imem_req_val,
  input  logic                  imem_req_rdy,
  output fetch_core_pkg::addr_t imem_req_addr,

  // Memory response side, in request order
  input  logic                  imem_resp_val,
  output logic                  imem_resp_rdy,
  input  fetch_core_pkg::addr_t imem_resp_addr,
  input  fetch_core_pkg::inst_t imem_resp_data,

  // Toward decode
  fetch_decode_if.fetch         fd
);

  // Limit in counter width
  localparam logic [`FC_IN_FLIGHT_BITS-1:0] max_in_flight =
    `FC_IN_FLIGHT_BITS'(`FC_MAX_IN_FLIGHT);

  logic                          req_xfer;
  logic                          resp_xfer;
  logic [`FC_IN_FLIGHT_BITS-1:0] in_flight;
  logic [`FC_IN_FLIGHT_BITS-1:0] in_flight_next;
  logic [31:0]                   next_addr;

  // --------------------
  // Transfers
  // --------------------

  assign req_xfer  = imem_req_val & imem_req_rdy;
  assign resp_xfer = imem_resp_val & imem_resp_rdy;

  // --------------------
  // In-flight count
  // --------------------

  // Up on request, down on response
  // Both on one edge leaves it unchanged
  always_comb begin
    in_flight_next = in_flight;
    if (req_xfer && !resp_xfer) begin
      in_flight_next = in_flight + 1'b1;
    end else if (resp_xfer && !req_xfer) begin
      in_flight_next = in_flight - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight_next;
    end
  end

  // --------------------
  // Request address
  // --------------------

  // Word-sequential, one step per accepted request
  always_ff @(posedge clk) begin
    if (rst) begin
      next_addr <= `FC_RESET_ADDR;
    end else if (req_xfer) begin
      next_addr <= next_addr + 32'd4;
    end
  end

  // Request whenever below the limit
  assign imem_req_val  = (in_flight < max_in_flight);
  assign imem_req_addr = next_addr;

  // --------------------
  // Response path
  // --------------------

  // Straight to decode, no buffering
  assign fd.val        = imem_resp_val;
  assign fd.pc         = imem_resp_addr;
  assign fd.inst       = imem_resp_data;
  // Decode back-pressure goes to memory
  assign imem_resp_rdy = fd.rdy;

endmodule

//--- rtl/inst_decode.sv
// Instruction decode stage
// Field split, operand read, busy-register scoreboard, output register

`timescale 1ns/100ps
`include "fetch_core_macros.svh"

module inst_decode (
  input logic                clk,
  input logic                rst,
  fetch_decode_if.decode     fd,
  regfile_if.read            rf,
  decode_execute_if.producer dx
);
  import fetch_core_pkg::*;

  opcode_t                 opcode;
  reg_idx_t                rd;
  reg_idx_t                rs1;
  reg_idx_t                rs2;
  imm_t                    imm;
  logic                    uses_rs1;
  logic                    uses_rs2;
  logic                    writes_rd;
  logic                    hazard;
  logic                    in_xfer;
  word_t                   b_sel;
  logic [`FC_NUM_REGS-1:0] busy;
  logic                    out_val;
  addr_t                   out_pc;
  opcode_t                 out_op;
  reg_idx_t                out_rd;
  word_t                   out_a;
  word_t                   out_b;

  // --------------------
  // Field split
  // --------------------

  assign opcode = fd.inst[31:28];
  assign rd     = fd.inst[27:24];
  assign rs1    = fd.inst[23:20];
  assign rs2    = fd.inst[19:16];
  assign imm    = fd.inst[15:0];

  // Which fields are live for this opcode
  always_comb begin
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OP_ADDI: uses_rs1 = 1'b1;
      default: ;
    endcase
  end

  // Writes to r0 count as no write
  assign writes_rd = (opcode >= OP_ADD) && (opcode <= OP_LUI) && (rd != '0);

  // Operand read and b select
  assign rf.rs1 = rs1;
  assign rf.rs2 = rs2;
  assign b_sel  = (opcode == OP_ADDI || opcode == OP_LUI) ? {16'h0000, imm} : rf.rdata2;

  // --------------------
  // Scoreboard
  // --------------------

  // Stall on any live register still in flight
  assign hazard = (uses_rs1 && busy[rs1]) || (uses_rs2 && busy[rs2]) ||
                  (writes_rd && busy[rd]);

  assign fd.rdy  = !(out_val && !dx.rdy) && !hazard;
  assign in_xfer = fd.val && fd.rdy;

  // Set on issue, cleared on retire
  // r0 never gets set since writes_rd excludes it
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (rf.retire_val) begin
        busy[rf.retire_rd] <= 1'b0;
      end
      if (in_xfer && writes_rd) begin
        busy[rd] <= 1'b1;
      end
    end
  end

  // --------------------
  // Output register
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
    end else if (in_xfer) begin
      out_val <= 1'b1;
    end else if (dx.rdy) begin
      out_val <= 1'b0;
    end
  end

  // Payload held until execute takes it
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      out_pc <= fd.pc;
      out_op <= opcode;
      out_rd <= rd;
      out_a  <= rf.rdata1;
      out_b  <= b_sel;
    end
  end

  assign dx.val = out_val;
  assign dx.pc  = out_pc;
  assign dx.op  = out_op;
  assign dx.rd  = out_rd;
  assign dx.a   = out_a;
  assign dx.b   = out_b;

endmodule

//--- rtl/result_writeback.sv
// Result stage
// Register file, result port register, retire notice to decode

`timescale 1ns/100ps
`include "fetch_core_macros.svh"

module result_writeback (
  input  logic                     clk,
  input  logic                     rst,
  execute_result_if.consumer       xr,
  regfile_if.regfile               rf,
  output logic                     res_val,
  input  logic                     res_rdy,
  output fetch_core_pkg::addr_t    res_pc,
  output fetch_core_pkg::reg_idx_t res_rd,
  output logic                     res_we,
  output fetch_core_pkg::word_t    res_data
);
  import fetch_core_pkg::*;

  word_t regs [`FC_NUM_REGS];
  logic  in_xfer;
  logic  res_xfer;

  assign xr.rdy   = !res_val || res_rdy;
  assign in_xfer  = xr.val && xr.rdy;
  assign res_xfer = res_val && res_rdy;

  // --------------------
  // Result register
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      res_val <= 1'b0;
    end else if (in_xfer) begin
      res_val <= 1'b1;
    end else if (res_rdy) begin
      res_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      res_pc   <= xr.pc;
      res_rd   <= xr.rd;
      res_we   <= xr.we;
      res_data <= xr.data;
    end
  end

  // --------------------
  // Register file
  // --------------------

  // Written only when the result leaves
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FC_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (res_xfer && res_we && (res_rd != '0)) begin
      regs[res_rd] <= res_data;
    end
  end

  // r0 hardwired to zero
  assign rf.rdata1 = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
  assign rf.rdata2 = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

  // Clears the busy bit in the same edge as the write
  assign rf.retire_val = res_xfer && res_we;
  assign rf.retire_rd  = res_rd;

endmodule
